/* hw/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN    = 64;
    localparam int HALF    = XLEN / 2;
    localparam int SHAMT_W = 6;        // log2 of XLEN

    // execute opcodes
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        MUL,
        DIV,
        DIVU,
        REM,
        REMU
    } ex_op_e;

    typedef struct packed {
        logic [HALF-1:0] hi;
        logic [HALF-1:0] lo;
    } ex_half_s;

    // one operand word, seen whole or as two halves
    typedef union packed {
        logic [XLEN-1:0] dword;
        ex_half_s        word;
    } ex_word_u;

endpackage

/* hw/ex_op_if.sv */
`timescale 1ns/100ps

interface ex_op_if import ex_pkg::*; ();

    ex_op_e   op;      // latched opcode
    ex_word_u src1;
    ex_word_u src2;
    logic     word;    // W form, low 32 bits only
    logic     go;      // one cycle after the latch

    modport issue (
        output op, src1, src2, word, go
    );

    modport unit (
        input op, src1, src2, word, go
    );

    modport result (
        input op, word, go
    );

endinterface

/* hw/ex_issue.sv */
`timescale 1ns/100ps

module ex_issue import ex_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  ex_op_e   op,
    input  ex_word_u src1,
    input  ex_word_u src2,
    input  logic     word,
    input  logic     done,
    output logic     busy,
    ex_op_if.issue   opb
);

    logic busy_q;
    logic accept;

    // drop busy on the same edge that registers done
    assign busy   = busy_q & ~done;
    assign accept = start & ~busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            opb.go <= 1'b0;
        end else begin
            opb.go <= accept;           // single pulse per operation
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operation held steady while the units work on it
    always_ff @(posedge clk) begin
        if (accept) begin
            opb.op   <= op;
            opb.src1 <= src1;
            opb.src2 <= src2;
            opb.word <= word;
        end
    end

endmodule

/* hw/alu_core.sv */
`timescale 1ns/100ps

module alu_core import ex_pkg::*; (
    ex_op_if.unit    opb,
    output ex_word_u alu_res
);

    ex_word_u           a;
    ex_word_u           b;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    assign a = opb.src1;
    assign b = opb.src2;

    // W shifts only look at five bits of the amount
    assign shamt = opb.word ? {1'b0, b.word.lo[SHAMT_W-2:0]} : b.dword[SHAMT_W-1:0];

    assign lt_s = $signed(a.dword) < $signed(b.dword);
    assign lt_u = a.dword < b.dword;

    always_comb begin
        alu_res.dword = '0;             // multiply and divide ops land here
        case (opb.op)
            ADD: begin
                if (opb.word) begin
                    alu_res.word.lo = a.word.lo + b.word.lo;
                end else begin
                    alu_res.dword = a.dword + b.dword;
                end
            end
            SUB: begin
                if (opb.word) begin
                    alu_res.word.lo = a.word.lo - b.word.lo;
                end else begin
                    alu_res.dword = a.dword - b.dword;
                end
            end
            AND:  alu_res.dword = a.dword & b.dword;
            OR:   alu_res.dword = a.dword | b.dword;
            XOR:  alu_res.dword = a.dword ^ b.dword;
            SLT:  alu_res.dword = {{(XLEN-1){1'b0}}, lt_s};
            SLTU: alu_res.dword = {{(XLEN-1){1'b0}}, lt_u};
            SLL: begin
                // low half is already right for sllw
                alu_res.dword = a.dword << shamt;
            end
            SRL: begin
                if (opb.word) begin
                    alu_res.word.lo = a.word.lo >> shamt;
                end else begin
                    alu_res.dword = a.dword >> shamt;
                end
            end
            SRA: begin
                if (opb.word) begin
                    alu_res.word.lo = $unsigned($signed(a.word.lo) >>> shamt);
                end else begin
                    alu_res.dword = $unsigned($signed(a.dword) >>> shamt);
                end
            end
            default: alu_res.dword = '0;
        endcase
    end

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/100ps

module mul_unit import ex_pkg::*; #(
    parameter int MUL_BITS = 2          // 1, 2 or 4
) (
    input  logic     clk,
    input  logic     rst_n,
    ex_op_if.unit    opb,
    output ex_word_u mul_res,
    output logic     mul_fin
);

    localparam int STEPS = XLEN / MUL_BITS;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic             start_mul;
    logic             running;
    logic [CNT_W-1:0] cnt;             // steps left
    logic [XLEN-1:0]  acc;
    logic [XLEN-1:0]  mcand;
    logic [XLEN-1:0]  mplier;
    logic [XLEN-1:0]  acc_nxt;

    assign start_mul = opb.go && (opb.op == MUL);

    // add one shifted multiplicand per set multiplier bit
    always_comb begin
        acc_nxt = acc;
        for (int i = 0; i < MUL_BITS; i++) begin
            if (mplier[i]) begin
                acc_nxt = acc_nxt + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            mul_fin <= 1'b0;
        end else begin
            mul_fin <= 1'b0;
            if (start_mul) begin
                running <= 1'b1;
                cnt     <= CNT_W'(STEPS);
            end else if (running) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    running <= 1'b0;
                    mul_fin <= 1'b1;   // acc complete next cycle
                end
            end
        end
    end

    // low product bits match for signed and unsigned operands
    always_ff @(posedge clk) begin
        if (start_mul) begin
            acc    <= '0;
            mcand  <= opb.src1.dword;
            mplier <= opb.src2.dword;
        end else if (running) begin
            acc    <= acc_nxt;
            mcand  <= mcand << MUL_BITS;
            mplier <= mplier >> MUL_BITS;
        end
    end

    assign mul_res.dword = acc;

endmodule

/* hw/div_unit.sv */
`timescale 1ns/100ps

module div_unit import ex_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    ex_op_if.unit    opb,
    output ex_word_u div_res,
    output logic     div_fin
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic             start_div;
    logic             sgn_op;
    logic             is_rem;
    logic [XLEN-1:0]  ext1;            // dividend after word narrowing
    logic [XLEN-1:0]  ext2;            // divisor after word narrowing
    logic             neg1;
    logic             neg2;
    logic [XLEN-1:0]  mag1;
    logic [XLEN-1:0]  mag2;

    logic             running;
    logic [CNT_W-1:0] cnt;
    logic [XLEN-1:0]  quo;
    logic [XLEN-1:0]  rem;
    logic [XLEN-1:0]  dvs;
    logic             q_neg;
    logic             r_neg;
    logic             want_rem;

    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;
    logic             fits;
    logic [XLEN-1:0]  quo_nxt;
    logic [XLEN-1:0]  rem_nxt;
    logic [XLEN-1:0]  q_fix;
    logic [XLEN-1:0]  r_fix;

    assign start_div = opb.go && (opb.op inside {DIV, DIVU, REM, REMU});
    assign sgn_op    = (opb.op == DIV) || (opb.op == REM);
    assign is_rem    = (opb.op == REM) || (opb.op == REMU);

    always_comb begin
        if (opb.word) begin
            ext1 = {{HALF{sgn_op & opb.src1.word.lo[HALF-1]}}, opb.src1.word.lo};
            ext2 = {{HALF{sgn_op & opb.src2.word.lo[HALF-1]}}, opb.src2.word.lo};
        end else begin
            ext1 = opb.src1.dword;
            ext2 = opb.src2.dword;
        end
    end

    assign neg1 = sgn_op & ext1[XLEN-1];
    assign neg2 = sgn_op & ext2[XLEN-1];
    assign mag1 = neg1 ? -ext1 : ext1;
    assign mag2 = neg2 ? -ext2 : ext2;

    // one restoring step, remainder may briefly need an extra bit
    assign shifted = {rem, quo[XLEN-1]};
    assign diff    = shifted - {1'b0, dvs};
    assign fits    = shifted >= {1'b0, dvs};
    assign rem_nxt = fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
    assign quo_nxt = {quo[XLEN-2:0], fits};

    // min over -1 needs nothing special, magnitudes wrap back to min
    assign q_fix = q_neg ? -quo_nxt : quo_nxt;
    assign r_fix = r_neg ? -rem_nxt : rem_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            div_fin <= 1'b0;
        end else begin
            div_fin <= 1'b0;
            if (start_div) begin
                if (ext2 == '0) begin
                    div_fin <= 1'b1;   // zero divisor, answer known now
                end else begin
                    running <= 1'b1;
                    cnt     <= opb.word ? CNT_W'(HALF) : CNT_W'(XLEN);
                end
            end else if (running) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    running <= 1'b0;
                    div_fin <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_div) begin
            // word divides start with the dividend in the top half
            quo      <= opb.word ? {mag1[HALF-1:0], {HALF{1'b0}}} : mag1;
            rem      <= '0;
            dvs      <= mag2;
            q_neg    <= neg1 ^ neg2;
            r_neg    <= neg1;
            want_rem <= is_rem;
            div_res.dword <= is_rem ? ext1 : '1;    // divide by zero values
        end else if (running) begin
            quo <= quo_nxt;
            rem <= rem_nxt;
            if (cnt == CNT_W'(1)) begin
                div_res.dword <= want_rem ? r_fix : q_fix;
            end
        end
    end

endmodule

/* hw/ex_result.sv */
`timescale 1ns/100ps

module ex_result import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    ex_op_if.result         opb,
    input  ex_word_u        alu_res,
    input  ex_word_u        mul_res,
    input  logic            mul_fin,
    input  ex_word_u        div_res,
    input  logic            div_fin,
    output logic [XLEN-1:0] result,
    output logic            done
);

    logic     single;
    logic     take;
    logic     sext;
    ex_word_u pick;
    ex_word_u ext_val;

    assign single = !(opb.op inside {MUL, DIV, DIVU, REM, REMU});
    assign take   = (opb.go && single) || mul_fin || div_fin;

    // logic ops and compares have no W forms
    assign sext = opb.word && !(opb.op inside {AND, OR, XOR, SLT, SLTU});

    always_comb begin
        if (mul_fin) begin
            pick = mul_res;
        end else if (div_fin) begin
            pick = div_res;
        end else begin
            pick = alu_res;
        end
    end

    always_comb begin
        ext_val = pick;
        if (sext) begin
            ext_val.word.hi = {HALF{pick.word.lo[HALF-1]}};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= take;
            if (take) begin
                result <= ext_val.dword;   // held until the next done
            end
        end
    end

endmodule

/* hw/ex_unit.sv */
`timescale 1ns/100ps

module ex_unit import ex_pkg::*; #(
    parameter int MUL_BITS = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  ex_op_e          op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    input  logic            word,
    output logic            busy,
    output logic [XLEN-1:0] result,
    output logic            done
);

    ex_op_if  opb ();

    ex_word_u alu_res;
    ex_word_u mul_res;
    ex_word_u div_res;
    logic     mul_fin;
    logic     div_fin;

    ex_issue u_issue (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .op    (op),
        .src1  (src1),
        .src2  (src2),
        .word  (word),
        .done  (done),
        .busy  (busy),
        .opb   (opb.issue)
    );

    alu_core u_alu (
        .opb     (opb.unit),
        .alu_res (alu_res)
    );

    mul_unit #(
        .MUL_BITS (MUL_BITS)
    ) u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .opb     (opb.unit),
        .mul_res (mul_res),
        .mul_fin (mul_fin)
    );

    div_unit u_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .opb     (opb.unit),
        .div_res (div_res),
        .div_fin (div_fin)
    );

    ex_result u_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .opb     (opb.result),
        .alu_res (alu_res),
        .mul_res (mul_res),
        .mul_fin (mul_fin),
        .div_res (div_res),
        .div_fin (div_fin),
        .result  (result),
        .done    (done)
    );

endmodule

/* tb/tb_ex_unit.sv */
`timescale 1ns/100ps

module tb_ex_unit import ex_pkg::*; ();

    localparam int NUM_OPS    = 312;
    localparam int OP_LIMIT   = 100;                    // cycles allowed per operation
    localparam int MAX_CYCLES = NUM_OPS * (OP_LIMIT + 2) + 3 + 20;

    logic        clk;
    logic        rst_n;
    logic        start;
    ex_op_e      op;
    logic [63:0] src1;
    logic [63:0] src2;
    logic        word;
    logic        busy;
    logic [63:0] result;
    logic        done;

    int          errors;
    int          cycles;
    logic [31:0] lfsr;

    ex_unit UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .word   (word),
        .busy   (busy),
        .result (result),
        .done   (done)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("cycle limit of %0d reached before the tests finished", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic get_rand(input int nbits, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    function automatic logic [63:0] sext32(input logic [31:0] x);
        return {{32{x[31]}}, x};
    endfunction

    // RV64 semantics where W forms sign-extend the low word
    function automatic logic [63:0] expected_result(input ex_op_e o, input logic [63:0] a,
                                                    input logic [63:0] b, input logic w);
        logic [31:0]        a32;
        logic [31:0]        b32;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] sa32;
        logic signed [31:0] sb32;
        logic [63:0]        p;
        logic               ovf;
        a32  = a[31:0];
        b32  = b[31:0];
        sa   = a;
        sb   = b;
        sa32 = a32;
        sb32 = b32;
        p    = a * b;
        ovf  = w ? (a32 == 32'h8000_0000 && b32 == '1)
                 : (a == 64'h8000_0000_0000_0000 && b == '1);
        case (o)
            ADD:  return w ? sext32(a32 + b32) : a + b;
            SUB:  return w ? sext32(a32 - b32) : a - b;
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLT:  return {63'b0, sa < sb};
            SLTU: return {63'b0, a < b};
            SLL:  return w ? sext32(a32 << b[4:0]) : a << b[5:0];
            SRL:  return w ? sext32(a32 >> b[4:0]) : a >> b[5:0];
            SRA:  return w ? sext32($unsigned(sa32 >>> b[4:0])) : $unsigned(sa >>> b[5:0]);
            MUL:  return w ? sext32(p[31:0]) : p;
            DIV: begin
                if (w ? (b32 == 0) : (b == 0)) return '1;
                if (ovf) return w ? sext32(a32) : a;
                return w ? sext32($unsigned(sa32 / sb32)) : $unsigned(sa / sb);
            end
            DIVU: begin
                if (w ? (b32 == 0) : (b == 0)) return '1;
                return w ? sext32(a32 / b32) : a / b;
            end
            REM: begin
                if (w ? (b32 == 0) : (b == 0)) return w ? sext32(a32) : a;
                if (ovf) return '0;
                return w ? sext32($unsigned(sa32 % sb32)) : $unsigned(sa % sb);
            end
            REMU: begin
                if (w ? (b32 == 0) : (b == 0)) return w ? sext32(a32) : a;
                return w ? sext32(a32 % b32) : a % b;
            end
            default: return '0;
        endcase
    endfunction

    // runs one operation and may add a stray start while busy
    task automatic run_op(input ex_op_e o, input logic [63:0] a, input logic [63:0] b,
                          input logic w, input logic intrude);
        logic [63:0] want;
        logic        single;
        int          n;
        want   = expected_result(o, a, b, w);
        single = !(o inside {MUL, DIV, DIVU, REM, REMU});
        @(negedge clk);
        start = 1'b1;
        op    = o;
        src1  = a;
        src2  = b;
        word  = w;
        @(negedge clk);
        start = 1'b0;
        n     = 0;
        while (!done && n < OP_LIMIT) begin
            if (!busy) begin
                errors++;
                $display("busy was low at %0t while %s was still running", $time, o.name());
            end
            start = intrude && (n == 2);
            if (start) begin
                op   = ADD;                  // must be ignored
                src1 = ~a;
            end
            @(negedge clk);
            n++;
        end
        if (!done) begin
            errors++;
            $display("no done within %0d cycles after starting %s", OP_LIMIT, o.name());
        end else begin
            if (result !== want) begin
                errors++;
                $display("ERR %0t result (%s word=%0b) expected %h got %h",
                         $time, o.name(), w, want, result);
            end
            if (single && n != 1) begin
                errors++;
                $display("ERR %0t done_latency (%s) expected 1 got %0d", $time, o.name(), n);
            end
        end
    endtask

    task automatic random_ops(input ex_op_e o, input int count, input logic w);
        logic [63:0] a;
        logic [63:0] b;
        for (int i = 0; i < count; i++) begin
            get_rand(64, a);
            get_rand(64, b);
            if (o inside {DIV, DIVU, REM, REMU} && i % 2 == 1) begin
                b = $signed(b) >>> 36;       // shorter divisor for a bigger quotient
            end
            run_op(o, a, b, w, 1'b0);
        end
    endtask

    task automatic check_reset_state();
        if (busy !== 1'b0 || done !== 1'b0 || result !== 64'd0) begin
            errors++;
            $display("ERR %0t busy/done/result expected 0/0/0 got %b/%b/%h",
                     $time, busy, done, result);
        end
    endtask

    task automatic single_cycle_ops();
        random_ops(ADD, 20, 1'b0);
        random_ops(SUB, 20, 1'b0);
        random_ops(AND, 20, 1'b0);
        random_ops(OR, 20, 1'b0);
        random_ops(XOR, 20, 1'b0);
        random_ops(SLT, 20, 1'b0);
        random_ops(SLTU, 20, 1'b0);
        // W forms for add and sub, the rest must ignore the flag
        random_ops(ADD, 4, 1'b1);
        random_ops(SUB, 4, 1'b1);
        random_ops(AND, 4, 1'b1);
        random_ops(OR, 4, 1'b1);
        random_ops(XOR, 4, 1'b1);
        random_ops(SLT, 4, 1'b1);
        random_ops(SLTU, 4, 1'b1);
    endtask

    task automatic shift_ops();
        ex_op_e      s;
        logic [63:0] a;
        for (int k = 0; k < 3; k++) begin
            s = ex_op_e'(SLL + k);
            get_rand(64, a);
            a[63] = 1'b1;                    // sign fill visible
            a[31] = 1'b1;
            run_op(s, a, 64'd0, 1'b0, 1'b0);
            run_op(s, a, 64'd63, 1'b0, 1'b0);
            random_ops(s, 8, 1'b0);
            run_op(s, a, 64'd0, 1'b1, 1'b0);
            run_op(s, a, 64'd31, 1'b1, 1'b0);
            random_ops(s, 6, 1'b1);
        end
    endtask

    task automatic multiply_ops();
        logic [63:0] a;
        get_rand(64, a);
        run_op(MUL, 64'h8000_0000_0000_0000, '1, 1'b0, 1'b0);
        run_op(MUL, 64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 1'b0, 1'b0);
        run_op(MUL, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0, 1'b0);
        run_op(MUL, 64'd0, a, 1'b0, 1'b0);
        run_op(MUL, '1, '1, 1'b0, 1'b0);
        run_op(MUL, '1, a, 1'b0, 1'b0);
        random_ops(MUL, 8, 1'b0);
        run_op(MUL, 64'h8000_0000, '1, 1'b1, 1'b0);
        run_op(MUL, 64'h7fff_ffff, 64'h7fff_ffff, 1'b1, 1'b0);
        run_op(MUL, a, 64'd0, 1'b1, 1'b0);
        run_op(MUL, '1, '1, 1'b1, 1'b0);
        random_ops(MUL, 6, 1'b1);
    endtask

    task automatic divide_ops();
        ex_op_e      o;
        logic [63:0] a;
        for (int k = 0; k < 4; k++) begin
            o = ex_op_e'(DIV + k);
            random_ops(o, 6, 1'b0);
            random_ops(o, 6, 1'b1);
            get_rand(64, a);
            run_op(o, a, 64'd0, 1'b0, 1'b0);
            run_op(o, a, 64'h1234_5678_0000_0000, 1'b1, 1'b0);  // low word zero
            run_op(o, 64'h8000_0000_0000_0000, '1, 1'b0, 1'b0);
            run_op(o, 64'h8000_0000, 64'hffff_ffff, 1'b1, 1'b0);
        end
    endtask

    task automatic busy_handling();
        logic [63:0] a;
        logic [63:0] b;
        get_rand(64, a);
        get_rand(64, b);
        run_op(DIV, a, (b >> 20) | 64'd1, 1'b0, 1'b1);
        run_op(DIVU, a, b | 64'd1, 1'b1, 1'b1);
    endtask

    initial begin
        errors = 0;
        cycles = 0;
        lfsr   = 32'd58;
        clk    = 1'b0;
        rst_n  = 1'b0;
        start  = 1'b0;
        op     = ADD;
        src1   = '0;
        src2   = '0;
        word   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        single_cycle_ops();
        shift_ops();
        multiply_ops();
        divide_ops();
        busy_handling();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/ex_pkg.sv
hw/ex_op_if.sv
hw/ex_issue.sv
hw/alu_core.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/ex_result.sv
hw/ex_unit.sv
tb/tb_ex_unit.sv
